// ==== source/radio_ctrl_pkg.sv ====
package radio_ctrl_pkg;

  // Command bus and NCO widths
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [31:0] phase_t;
  typedef logic [3:0]  chan_t;
  typedef logic [5:0]  rate_t;

  // Transmit timing fields
  typedef logic [6:0] latency_t;
  typedef logic [4:0] ptt_hang_t;
  typedef logic [9:0] cw_hang_t;

  // Configuration shared by all blocks
  typedef struct packed {
    logic [1:0] rx_rate;
    chan_t      last_chan;
    logic       duplex;
    cw_hang_t   cw_hang;
    latency_t   tx_latency;
    ptt_hang_t  ptt_hang;
  } radio_cfg_t;

  // ----------------------------------------------------------------------
  // Command addresses
  // ----------------------------------------------------------------------
  localparam cmd_addr_t ADDR_CONTROL   = 6'h00;
  localparam cmd_addr_t ADDR_TX_FREQ   = 6'h01;
  localparam cmd_addr_t ADDR_CW_HANG   = 6'h10;
  localparam cmd_addr_t ADDR_TX_TIMING = 6'h17;

  // Receiver frequency slots, entry k tunes receiver k
  localparam int MAX_RX = 12;
  localparam cmd_addr_t [MAX_RX-1:0] ADDR_RX_FREQ = {
    6'h16, 6'h15, 6'h14, 6'h13, 6'h12, 6'h08,
    6'h07, 6'h06, 6'h05, 6'h04, 6'h03, 6'h02
  };

  // NCO slot of the transmitter
  localparam chan_t TX_NCO_INDEX = 4'd15;

  // Rounding term added before the phase word is cut out
  localparam phase_t FREQ_ROUND = 32'd16777216;

  // 2^57 / clock, 61.44 MHz entry trimmed for the oscillator offset
  function automatic phase_t freq_scale(input int unsigned clock);
    case (clock)
      61440000: return 32'd2345640077;
      79872000: return 32'd1804326773;
      76800000: return 32'd1876499845;
      default:  return 32'd1954687338;
    endcase
  endfunction

  // Decimation for 48 ksps
  function automatic rate_t rate48(input int unsigned clock);
    case (clock)
      61440000: return 6'd16;
      79872000: return 6'd16;
      76800000: return 6'd40;
      default:  return 6'd24;
    endcase
  endfunction

endpackage

// ==== source/radio_sig_pkg.sv ====
package radio_sig_pkg;

  // Receiver side
  typedef logic [23:0] rx_sample_t;

  typedef struct packed {
    rx_sample_t i;
    rx_sample_t q;
  } rx_iq_t;

  // Transmit side, I in the upper half as on the host stream
  typedef logic signed [15:0] tx_sample_t;

  typedef struct packed {
    tx_sample_t i;
    tx_sample_t q;
  } tx_iq_t;

  // CW envelope, top 15 bits drive the I input
  typedef logic [18:0] cw_level_t;

  localparam cw_level_t CW_LEVEL_MAX = 19'h4D800;

  // Upstream receive stream
  typedef struct packed {
    rx_sample_t tdata;
    logic       tlast;
    logic       tvalid;
  } rx_stream_t;

endpackage

// ==== source/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int unsigned CLK_FREQ = 76800000
) (
  input  logic                       clk,
  input  logic                       rst_all,
  input  radio_ctrl_pkg::cmd_addr_t  cmd_addr_i,
  input  radio_ctrl_pkg::cmd_data_t  cmd_data_i,
  input  logic                       cmd_rqst_i,
  output logic                       cmd_ack_o,
  output logic                       freq_latch_o,
  output logic                       freq_commit_o,
  output radio_ctrl_pkg::radio_cfg_t cfg_o,
  output radio_ctrl_pkg::rate_t      rate_o
);

  localparam radio_ctrl_pkg::rate_t RATE48 = radio_ctrl_pkg::rate48(CLK_FREQ);

  // Idle, then three cycles for the frequency multiply
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_FREQ1,
    CMD_FREQ2,
    CMD_FREQ3
  } cmd_state_t;

  cmd_state_t                 state;
  radio_ctrl_pkg::radio_cfg_t cfg_q;
  logic                       is_freq;

  // Any NCO address starts the busy sequence
  always_comb begin
    is_freq = (cmd_addr_i == radio_ctrl_pkg::ADDR_TX_FREQ);
    for (int k = 0; k < radio_ctrl_pkg::MAX_RX; k++) begin
      if (cmd_addr_i == radio_ctrl_pkg::ADDR_RX_FREQ[k]) is_freq = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state <= CMD_IDLE;
      cfg_q <= '0;
      // Default latency 10 ms, PTT hang 4 ms
      cfg_q.tx_latency <= 7'd10;
      cfg_q.ptt_hang   <= 5'd4;
    end else begin
      case (state)
        CMD_IDLE: begin
          if (cmd_rqst_i) begin
            if (is_freq) state <= CMD_FREQ1;
            // Control writes land at once, no ack
            case (cmd_addr_i)
              radio_ctrl_pkg::ADDR_CONTROL: begin
                cfg_q.rx_rate   <= cmd_data_i[25:24];
                cfg_q.last_chan <= cmd_data_i[6:3];
                cfg_q.duplex    <= cmd_data_i[2];
              end
              radio_ctrl_pkg::ADDR_CW_HANG: begin
                cfg_q.cw_hang <= {cmd_data_i[31:24], cmd_data_i[17:16]};
              end
              radio_ctrl_pkg::ADDR_TX_TIMING: begin
                cfg_q.tx_latency <= cmd_data_i[6:0];
                cfg_q.ptt_hang   <= cmd_data_i[12:8];
              end
              default: ;
            endcase
          end
        end
        CMD_FREQ1: state <= CMD_FREQ2;
        CMD_FREQ2: state <= CMD_FREQ3;
        default:   state <= CMD_IDLE;
      endcase
    end
  end

  // Product latched in FREQ2, written in FREQ3
  assign freq_latch_o  = (state == CMD_FREQ2);
  assign freq_commit_o = (state == CMD_FREQ3);
  assign cmd_ack_o     = (state == CMD_FREQ3);

  assign cfg_o = cfg_q;

  // 48, 96, 192 and 384 ksps
  assign rate_o = RATE48 >> cfg_q.rx_rate;

endmodule

// ==== source/phase_bank.sv ====
`timescale 1ns/1ps

module phase_bank #(
  parameter int          NR       = 4,
  parameter int unsigned CLK_FREQ = 76800000
) (
  input  logic                             clk,
  input  logic                             rst_all,
  input  radio_ctrl_pkg::cmd_addr_t        cmd_addr_i,
  input  radio_ctrl_pkg::cmd_data_t        cmd_data_i,
  input  logic                             freq_latch_i,
  input  logic                             freq_commit_i,
  input  radio_ctrl_pkg::radio_cfg_t       cfg_i,
  output radio_ctrl_pkg::phase_t           tx_phase_o,
  output radio_ctrl_pkg::phase_t [NR-1:0]  rx_phase_o
);

  localparam logic [63:0] SCALE = 64'(radio_ctrl_pkg::freq_scale(CLK_FREQ));
  localparam logic [63:0] ROUND = 64'(radio_ctrl_pkg::FREQ_ROUND);

  logic [63:0]                     freq_prod;
  radio_ctrl_pkg::chan_t           nco_idx;
  radio_ctrl_pkg::chan_t           idx_q;
  radio_ctrl_pkg::phase_t          phase_q;
  radio_ctrl_pkg::phase_t          tx_phase;
  radio_ctrl_pkg::phase_t [NR-1:0] rx_phase;
  logic                            simplex;

  // Hz to phase increment, two cycles to settle
  assign freq_prod = 64'(cmd_data_i) * SCALE + ROUND;

  // ----------------------------------------------------------------------
  // Address to NCO slot
  // ----------------------------------------------------------------------
  always_comb begin
    // Slot 14 matches no receiver and not TX
    nco_idx = 4'd14;
    if (cmd_addr_i == radio_ctrl_pkg::ADDR_TX_FREQ) nco_idx = radio_ctrl_pkg::TX_NCO_INDEX;
    for (int k = 0; k < radio_ctrl_pkg::MAX_RX; k++) begin
      if (cmd_addr_i == radio_ctrl_pkg::ADDR_RX_FREQ[k]) begin
        nco_idx = radio_ctrl_pkg::chan_t'(k);
      end
    end
  end

  // Stage 1
  always_ff @(posedge clk) begin
    if (freq_latch_i) begin
      phase_q <= freq_prod[56:25];
      idx_q   <= nco_idx;
    end
  end

  // Single receiver without duplex follows TX
  assign simplex = !cfg_i.duplex && (cfg_i.last_chan == 4'd0);

  // Stage 2, phase registers
  always_ff @(posedge clk) begin
    if (rst_all) begin
      tx_phase <= '0;
      rx_phase <= '0;
    end else if (freq_commit_i) begin
      if (idx_q == radio_ctrl_pkg::TX_NCO_INDEX) begin
        tx_phase <= phase_q;
        if (simplex) rx_phase[0] <= phase_q;
      end
      // Slots at NR and above fall through
      for (int c = 0; c < NR; c++) begin
        if (idx_q == radio_ctrl_pkg::chan_t'(c)) begin
          // RX0 write in simplex keeps the TX tuning
          if (c == 0 && simplex) rx_phase[c] <= tx_phase;
          else rx_phase[c] <= phase_q;
        end
      end
    end
  end

  assign tx_phase_o = tx_phase;
  assign rx_phase_o = rx_phase;

endmodule

// ==== source/tx_keyer.sv ====
`timescale 1ns/1ps

module tx_keyer (
  input  logic                       clk,
  input  logic                       rst_all,
  input  logic                       run_i,
  input  logic                       qmsec_pulse_i,
  input  logic                       ext_keydown_i,
  input  radio_sig_pkg::tx_iq_t      tx_tdata_i,
  input  logic [3:0]                 tx_tuser_i,
  input  logic                       tx_tvalid_i,
  input  logic                       fir_ready_i,
  input  radio_ctrl_pkg::radio_cfg_t cfg_i,
  output logic                       tx_tready_o,
  output radio_sig_pkg::tx_iq_t      tx_bb_o,
  output logic                       tx_on_o,
  output logic                       cw_on_o
);

  typedef enum logic [2:0] {
    NOTX,
    PRETX,
    PTTTX,
    CWTX,
    CWHANG
  } tx_state_t;

  tx_state_t                 state;
  tx_state_t                 state_next;
  logic [8:0]                timer;
  logic [8:0]                timer_next;
  radio_sig_pkg::cw_level_t  level;
  radio_sig_pkg::cw_level_t  level_next;
  radio_sig_pkg::tx_iq_t     sample;
  radio_sig_pkg::tx_iq_t     sample_next;
  logic [10:0]               accum;
  logic                      accum_incr;
  logic                      accum_decr;
  logic                      accum_nz;
  logic                      cwx;
  logic                      ptt;
  logic                      cw_key;
  logic [8:0]                latency_q4;
  logic [8:0]                ptt_hang_q4;
  radio_sig_pkg::cw_level_t  hang_level;

  // Keys from the host stream sideband
  assign cwx    = tx_tuser_i[2] & tx_tvalid_i;
  assign ptt    = tx_tuser_i[3] & tx_tvalid_i;
  assign cw_key = ext_keydown_i | cwx;

  // Times in quarter milliseconds
  assign latency_q4  = {cfg_i.tx_latency, 2'b00};
  assign ptt_hang_q4 = {2'b00, cfg_i.ptt_hang, 2'b00};
  assign hang_level  = {7'b0000000, cfg_i.cw_hang, 2'b00};

  assign accum_nz = |accum;

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state <= NOTX;
      timer <= '0;
      level <= '0;
      accum <= '0;
    end else begin
      state <= run_i ? state_next : NOTX;
      timer <= timer_next;
      level <= level_next;
      // Tape recorder mode, samples held back during PRETX
      if (accum_incr) accum <= accum + 11'd1;
      else if (accum_decr && accum_nz) accum <= accum - 11'd1;
    end
  end

  always_ff @(posedge clk) begin
    sample <= sample_next;
  end

  // ----------------------------------------------------------------------
  // Keying state machine
  // ----------------------------------------------------------------------
  always_comb begin
    state_next  = state;
    timer_next  = timer;
    level_next  = level;
    sample_next = sample;
    tx_tready_o = fir_ready_i;
    accum_incr  = 1'b0;
    accum_decr  = 1'b0;

    case (state)
      NOTX: begin
        sample_next = '0;
        level_next  = '0;
        timer_next  = latency_q4;
        // Drain what PRETX held back
        accum_decr  = ~fir_ready_i;
        tx_tready_o = fir_ready_i | accum_nz;
        if (cw_key | ptt) state_next = PRETX;
      end

      PRETX: begin
        // Stall to fill the buffer
        tx_tready_o = 1'b0;
        accum_incr  = fir_ready_i;
        if (timer != 9'd0) begin
          if (qmsec_pulse_i) timer_next = timer - 9'd1;
          if (!(cw_key | ptt)) state_next = NOTX;
        end else if (cw_key) begin
          state_next = CWTX;
        end else begin
          state_next = PTTTX;
        end
      end

      PTTTX: begin
        if (ext_keydown_i) begin
          state_next = CWTX;
        end else if (ptt) begin
          timer_next = ptt_hang_q4;
          if (fir_ready_i) sample_next = tx_tdata_i;
        end else if (timer != 9'd0) begin
          if (qmsec_pulse_i) timer_next = timer - 9'd1;
        end else begin
          state_next = NOTX;
        end
      end

      CWTX: begin
        if (cw_key) begin
          // Rising edge of the envelope
          if (level != radio_sig_pkg::CW_LEVEL_MAX) level_next = level + 19'd1;
          timer_next = latency_q4;
        end else if (timer != 9'd0) begin
          // Hold on for the buffer latency
          if (qmsec_pulse_i) timer_next = timer - 9'd1;
        end else if (level != 19'd0) begin
          level_next = level - 19'd1;
        end else begin
          // Level now counts the hang time
          timer_next = latency_q4;
          level_next = hang_level;
          state_next = CWHANG;
        end
      end

      CWHANG: begin
        if (cw_key) begin
          if (timer != 9'd0) begin
            if (qmsec_pulse_i) timer_next = timer - 9'd1;
          end else begin
            timer_next = latency_q4;
            level_next = '0;
            state_next = CWTX;
          end
        end else if (level != 19'd0) begin
          if (qmsec_pulse_i) level_next = level - 19'd1;
        end else begin
          state_next = NOTX;
        end
      end

      default: state_next = NOTX;
    endcase
  end

  assign tx_on_o = (state != NOTX);
  assign cw_on_o = (state == CWTX) || (state == CWHANG);

  // CW carrier on I only, else the latched sample
  always_comb begin
    if (state == CWTX) begin
      tx_bb_o.i = radio_sig_pkg::tx_sample_t'({1'b0, level[18:4]});
      tx_bb_o.q = '0;
    end else begin
      tx_bb_o = sample;
    end
  end

endmodule

// ==== source/rx_framer.sv ====
`timescale 1ns/1ps

module rx_framer #(
  parameter int NR = 4
) (
  input  logic                           clk,
  input  logic                           rst_all,
  input  radio_sig_pkg::rx_iq_t [NR-1:0] rx_iq_i,
  input  logic                           rx_rdy_i,
  input  logic                           rx_tready_i,
  input  radio_ctrl_pkg::radio_cfg_t     cfg_i,
  output radio_sig_pkg::rx_stream_t      rx_stream_o
);

  localparam radio_ctrl_pkg::chan_t MAX_CHAN = radio_ctrl_pkg::chan_t'(NR - 1);

  typedef enum logic [1:0] {
    RX_WAIT1,
    RX_I,
    RX_Q,
    RX_WAIT0
  } rx_state_t;

  rx_state_t             state;
  radio_ctrl_pkg::chan_t chan;
  radio_ctrl_pkg::chan_t last_chan;

  // Never run past the built receivers
  assign last_chan = (cfg_i.last_chan > MAX_CHAN) ? MAX_CHAN : cfg_i.last_chan;

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state <= RX_WAIT1;
      chan  <= '0;
    end else begin
      case (state)
        RX_WAIT1: begin
          chan <= '0;
          if (rx_rdy_i && rx_tready_i) state <= RX_I;
        end
        RX_I: state <= RX_Q;
        RX_Q: begin
          if (chan == last_chan) begin
            state <= RX_WAIT0;
          end else begin
            chan  <= chan + 4'd1;
            state <= RX_I;
          end
        end
        // One frame per ready level
        default: begin
          if (!rx_rdy_i) state <= RX_WAIT1;
        end
      endcase
    end
  end

  // One word per clock, no back-pressure inside a frame
  always_comb begin
    rx_stream_o.tvalid = (state == RX_I) || (state == RX_Q);
    rx_stream_o.tlast  = (state == RX_Q) && (chan == last_chan);
    case (state)
      RX_I:    rx_stream_o.tdata = rx_iq_i[chan].i;
      RX_Q:    rx_stream_o.tdata = rx_iq_i[chan].q;
      default: rx_stream_o.tdata = '0;
    endcase
  end

endmodule

// ==== source/radio_top.sv ====
`timescale 1ns/1ps

module radio_top #(
  parameter int          NR       = 4,
  parameter int unsigned CLK_FREQ = 76800000
) (
  input  logic                            clk,
  input  logic                            rst_all,
  // Command slave
  input  radio_ctrl_pkg::cmd_addr_t       cmd_addr_i,
  input  radio_ctrl_pkg::cmd_data_t       cmd_data_i,
  input  logic                            cmd_rqst_i,
  output logic                            cmd_ack_o,
  // Transmit
  input  radio_sig_pkg::tx_iq_t           tx_tdata_i,
  input  logic [3:0]                      tx_tuser_i,
  input  logic                            tx_tvalid_i,
  output logic                            tx_tready_o,
  input  logic                            run_i,
  input  logic                            qmsec_pulse_i,
  input  logic                            ext_keydown_i,
  input  logic                            fir_ready_i,
  // Receive
  input  radio_sig_pkg::rx_iq_t [NR-1:0]  rx_iq_i,
  input  logic                            rx_rdy_i,
  output radio_sig_pkg::rx_stream_t       rx_stream_o,
  input  logic                            rx_tready_i,
  // NCO, decimation and baseband
  output radio_ctrl_pkg::phase_t          tx_phase_o,
  output radio_ctrl_pkg::phase_t [NR-1:0] rx_phase_o,
  output radio_ctrl_pkg::rate_t           rate_o,
  output radio_sig_pkg::tx_iq_t           tx_bb_o,
  output logic                            tx_on_o,
  output logic                            cw_on_o
);

  radio_ctrl_pkg::radio_cfg_t cfg;
  logic                       freq_latch;
  logic                       freq_commit;

  cmd_decoder #(
    .CLK_FREQ(CLK_FREQ)
  ) cmd_decoder_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_rqst_i   (cmd_rqst_i),
    .cmd_ack_o    (cmd_ack_o),
    .freq_latch_o (freq_latch),
    .freq_commit_o(freq_commit),
    .cfg_o        (cfg),
    .rate_o       (rate_o)
  );

  // Reads the command bus directly during the busy cycles
  phase_bank #(
    .NR      (NR),
    .CLK_FREQ(CLK_FREQ)
  ) phase_bank_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .freq_latch_i (freq_latch),
    .freq_commit_i(freq_commit),
    .cfg_i        (cfg),
    .tx_phase_o   (tx_phase_o),
    .rx_phase_o   (rx_phase_o)
  );

  tx_keyer tx_keyer_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .run_i        (run_i),
    .qmsec_pulse_i(qmsec_pulse_i),
    .ext_keydown_i(ext_keydown_i),
    .tx_tdata_i   (tx_tdata_i),
    .tx_tuser_i   (tx_tuser_i),
    .tx_tvalid_i  (tx_tvalid_i),
    .fir_ready_i  (fir_ready_i),
    .cfg_i        (cfg),
    .tx_tready_o  (tx_tready_o),
    .tx_bb_o      (tx_bb_o),
    .tx_on_o      (tx_on_o),
    .cw_on_o      (cw_on_o)
  );

  rx_framer #(
    .NR(NR)
  ) rx_framer_i (
    .clk        (clk),
    .rst_all    (rst_all),
    .rx_iq_i    (rx_iq_i),
    .rx_rdy_i   (rx_rdy_i),
    .rx_tready_i(rx_tready_i),
    .cfg_i      (cfg),
    .rx_stream_o(rx_stream_o)
  );

endmodule

// ==== tests/radio_tb.sv ====
`timescale 1ns/1ps

module radio_tb;

  localparam int          NR         = 4;
  localparam int unsigned CLK_FREQ   = 76800000;
  localparam int          MAX_CYCLES = 20000;
  localparam int          CW_STEPS   = 300;
  // 2^57 / 76.8 MHz rounded to the nearest integer
  localparam logic [63:0] PHASE_SCALE = 64'd1876499845;
  localparam logic [5:0]  RATE_48K    = 6'd40;

  logic                                   clk = 1'b0;
  logic                                   rst_all;
  radio_ctrl_pkg::cmd_addr_t              cmd_addr;
  radio_ctrl_pkg::cmd_data_t              cmd_data;
  logic                                   cmd_rqst;
  logic                                   cmd_ack;
  radio_sig_pkg::tx_iq_t                  tx_tdata;
  logic [3:0]                             tx_tuser;
  logic                                   tx_tvalid;
  logic                                   tx_tready;
  logic                                   run;
  logic                                   qmsec = 1'b0;
  logic                                   ext_keydown;
  logic                                   fir_ready;
  radio_sig_pkg::rx_iq_t [NR-1:0]         rx_iq;
  logic                                   rx_rdy;
  radio_sig_pkg::rx_stream_t              rx_stream;
  logic                                   rx_tready;
  radio_ctrl_pkg::phase_t                 tx_phase;
  radio_ctrl_pkg::phase_t [NR-1:0]        rx_phase;
  radio_ctrl_pkg::rate_t                  rate;
  radio_sig_pkg::tx_iq_t                  tx_bb;
  logic                                   tx_on;
  logic                                   cw_on;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          pulses_seen = 0;
  logic [3:0]  qcnt = '0;
  logic [24:0] frame_q[$];
  logic [24:0] exp_word;
  logic        in_frame = 1'b0;

  radio_top #(
    .NR      (NR),
    .CLK_FREQ(CLK_FREQ)
  ) dut_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .cmd_addr_i   (cmd_addr),
    .cmd_data_i   (cmd_data),
    .cmd_rqst_i   (cmd_rqst),
    .cmd_ack_o    (cmd_ack),
    .tx_tdata_i   (tx_tdata),
    .tx_tuser_i   (tx_tuser),
    .tx_tvalid_i  (tx_tvalid),
    .tx_tready_o  (tx_tready),
    .run_i        (run),
    .qmsec_pulse_i(qmsec),
    .ext_keydown_i(ext_keydown),
    .fir_ready_i  (fir_ready),
    .rx_iq_i      (rx_iq),
    .rx_rdy_i     (rx_rdy),
    .rx_stream_o  (rx_stream),
    .rx_tready_i  (rx_tready),
    .tx_phase_o   (tx_phase),
    .rx_phase_o   (rx_phase),
    .rate_o       (rate),
    .tx_bb_o      (tx_bb),
    .tx_on_o      (tx_on),
    .cw_on_o      (cw_on)
  );

  always #4 clk = ~clk;

  // Quarter millisecond tick shortened to every 16 clocks
  always @(negedge clk) begin
    if (rst_all) begin
      qcnt  <= '0;
      qmsec <= 1'b0;
    end else begin
      qcnt  <= qcnt + 4'd1;
      qmsec <= (qcnt == 4'd15);
    end
  end

  // Ticks as the DUT sees them
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (qmsec) pulses_seen <= pulses_seen + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  function automatic radio_ctrl_pkg::phase_t phase_word(input radio_ctrl_pkg::cmd_data_t data);
    logic [63:0] prod;
    prod = 64'(data) * PHASE_SCALE + 64'(radio_ctrl_pkg::FREQ_ROUND);
    return prod[56:25];
  endfunction

  function automatic radio_ctrl_pkg::rate_t rate_for_code(input logic [1:0] code);
    return RATE_48K >> code;
  endfunction

  // CW carrier on I from the top bits of the envelope
  function automatic logic [15:0] cw_carrier_i(input int unsigned level);
    logic [18:0] lv;
    lv = 19'(level);
    return {1'b0, lv[18:4]};
  endfunction

  function automatic radio_ctrl_pkg::cmd_data_t ctrl_word(input logic [1:0] rx_rate,
                                                          input logic [3:0] last_chan,
                                                          input logic duplex);
    radio_ctrl_pkg::cmd_data_t d;
    d = '0;
    d[25:24] = rx_rate;
    d[6:3]   = last_chan;
    d[2]     = duplex;
    return d;
  endfunction

  // I then Q per channel with tlast on the final Q
  task automatic build_frame(input int last_chan);
    for (int c = 0; c <= last_chan; c++) begin
      frame_q.push_back({1'b0, rx_iq[c].i});
      frame_q.push_back({(c == last_chan), rx_iq[c].q});
    end
  endtask

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("Error %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic check_condition(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error %0t: %s", $time, what);
    end
  endtask

  // Stream comparison sampled mid cycle
  always @(negedge clk) begin
    if (!rst_all) begin
      if (rx_stream.tvalid) begin
        if (frame_q.size() == 0) begin
          check_condition(1'b0, "stream word sent with no frame due");
        end else begin
          exp_word = frame_q.pop_front();
          compare_value(64'({rx_stream.tlast, rx_stream.tdata}), 64'(exp_word), "stream word");
          in_frame = !exp_word[24];
        end
      end else if (in_frame) begin
        check_condition(1'b0, "stream paused inside a frame");
        in_frame = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // Command bus
  // ------------------------------------------------------------------
  task automatic write_ctrl(input radio_ctrl_pkg::cmd_addr_t addr,
                            input radio_ctrl_pkg::cmd_data_t data);
    cmd_addr = addr;
    cmd_data = data;
    cmd_rqst = 1'b1;
    @(negedge clk);
    cmd_rqst = 1'b0;
  endtask

  // Bus held until the phase register is written
  task automatic freq_write(input radio_ctrl_pkg::cmd_addr_t addr,
                            input radio_ctrl_pkg::cmd_data_t data);
    cmd_addr = addr;
    cmd_data = data;
    cmd_rqst = 1'b1;
    for (int k = 1; k <= 4; k++) begin
      @(negedge clk);
      cmd_rqst = 1'b0;
      compare_value(64'(cmd_ack), 64'(k == 3), "cmd_ack after frequency request");
    end
  endtask

  initial begin
    radio_ctrl_pkg::cmd_data_t d1;
    radio_ctrl_pkg::cmd_data_t d2;
    radio_sig_pkg::tx_iq_t     exp_bb;
    logic [15:0]               prev_i;
    int                        n;
    int                        base;

    void'($urandom(75410));
    rst_all     = 1'b1;
    cmd_addr    = '0;
    cmd_data    = '0;
    cmd_rqst    = 1'b0;
    tx_tdata    = '0;
    tx_tuser    = '0;
    tx_tvalid   = 1'b0;
    run         = 1'b1;
    ext_keydown = 1'b0;
    fir_ready   = 1'b1;
    rx_iq       = '0;
    rx_rdy      = 1'b0;
    rx_tready   = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_all = 1'b0;
    @(negedge clk);

    check_condition(!cmd_ack && !tx_on && !cw_on && !rx_stream.tvalid,
                    "outputs active after reset");
    compare_value(64'(tx_tready), 64'(fir_ready), "tx_tready after reset");

    // Frequency writes with duplex
    write_ctrl(radio_ctrl_pkg::ADDR_CONTROL, ctrl_word(2'd0, 4'd3, 1'b1));
    d1 = $urandom;
    freq_write(6'h01, d1);
    compare_value(64'(tx_phase), 64'(phase_word(d1)), "tx_phase");
    for (int k = 0; k < NR; k++) begin
      d1 = $urandom;
      freq_write(6'(8'h02 + k), d1);
      compare_value(64'(rx_phase[k]), 64'(phase_word(d1)), "rx_phase");
    end

    // Simplex mode where receiver 0 follows TX
    write_ctrl(radio_ctrl_pkg::ADDR_CONTROL, ctrl_word(2'd0, 4'd0, 1'b0));
    d1 = $urandom;
    freq_write(6'h01, d1);
    compare_value(64'(tx_phase), 64'(phase_word(d1)), "tx_phase in simplex");
    compare_value(64'(rx_phase[0]), 64'(phase_word(d1)), "rx_phase[0] following TX");
    // Receiver 0 retuned alone in duplex before the simplex write
    write_ctrl(radio_ctrl_pkg::ADDR_CONTROL, ctrl_word(2'd0, 4'd0, 1'b1));
    d2 = $urandom;
    freq_write(6'h02, d2);
    compare_value(64'(rx_phase[0]), 64'(phase_word(d2)), "rx_phase[0] in duplex");
    write_ctrl(radio_ctrl_pkg::ADDR_CONTROL, ctrl_word(2'd0, 4'd0, 1'b0));
    d2 = $urandom;
    freq_write(6'h02, d2);
    compare_value(64'(rx_phase[0]), 64'(phase_word(d1)), "rx_phase[0] simplex write");
    compare_value(64'(tx_phase), 64'(phase_word(d1)), "tx_phase after receiver 0 write");

    // Rate select
    for (int r = 0; r < 4; r++) begin
      write_ctrl(radio_ctrl_pkg::ADDR_CONTROL, ctrl_word(2'(r), 4'd2, 1'b1));
      compare_value(64'(rate), 64'(rate_for_code(2'(r))), "rate_o");
    end

    // Two frames for two rx_rdy levels
    for (int f = 0; f < 2; f++) begin
      for (int c = 0; c < NR; c++) begin
        rx_iq[c].i = 24'($urandom);
        rx_iq[c].q = 24'($urandom);
      end
      build_frame(2);
      rx_rdy = 1'b1;
      n = 0;
      while (frame_q.size() != 0 && n < 50) begin
        @(negedge clk);
        n++;
      end
      check_condition(frame_q.size() == 0, "frame not completed");
      repeat (10) @(negedge clk);
      rx_rdy = 1'b0;
      repeat (3) @(negedge clk);
    end

    // ------------------------------------------------------------------
    // PTT keying with latency 2 ms and hang 1 ms
    // ------------------------------------------------------------------
    write_ctrl(radio_ctrl_pkg::ADDR_TX_TIMING, 32'h0000_0102);
    tx_tuser  = 4'b1000;
    tx_tvalid = 1'b1;
    @(negedge clk);
    check_condition(tx_on, "tx_on did not rise on PTT");
    base = pulses_seen;
    n = 0;
    while (!tx_tready && n < 400) begin
      check_condition(tx_on, "tx_on dropped during latency");
      @(negedge clk);
      n++;
    end
    check_condition(tx_tready, "tx_tready stayed low after latency");
    compare_value(64'(pulses_seen - base), 64'd8, "latency ticks");
    compare_value(64'(tx_bb), 64'd0, "tx_bb before first sample");
    exp_bb = '0;
    repeat (24) begin
      tx_tdata  = $urandom;
      fir_ready = 1'($urandom);
      @(negedge clk);
      if (fir_ready) exp_bb = tx_tdata;
      compare_value(64'(tx_bb), 64'(exp_bb), "tx_bb during PTT");
      compare_value(64'(tx_tready), 64'(fir_ready), "tx_tready during PTT");
    end
    fir_ready = 1'b1;
    tx_tuser  = '0;
    tx_tvalid = 1'b0;
    base = pulses_seen;
    n = 0;
    while (tx_on && n < 400) begin
      @(negedge clk);
      n++;
    end
    check_condition(!tx_on, "tx_on stayed high after PTT hang");
    compare_value(64'(pulses_seen - base), 64'd4, "PTT hang ticks");

    // ------------------------------------------------------------------
    // CW keying with a hang of 1
    // ------------------------------------------------------------------
    write_ctrl(radio_ctrl_pkg::ADDR_CW_HANG, 32'h0001_0000);
    ext_keydown = 1'b1;
    n = 0;
    while (!cw_on && n < 400) begin
      @(negedge clk);
      n++;
    end
    check_condition(cw_on, "cw_on did not rise on key down");
    prev_i = '0;
    for (int m = 0; m < CW_STEPS; m++) begin
      compare_value(64'($unsigned(tx_bb.i)), 64'(cw_carrier_i(m)), "CW envelope on I");
      compare_value(64'($unsigned(tx_bb.q)), 64'd0, "CW Q");
      check_condition($unsigned(tx_bb.i) >= prev_i, "CW envelope fell while keyed");
      check_condition($unsigned(tx_bb.i) <= {1'b0, radio_sig_pkg::CW_LEVEL_MAX[18:4]},
                      "CW envelope above its limit");
      prev_i = tx_bb.i;
      @(negedge clk);
    end
    ext_keydown = 1'b0;
    base = pulses_seen;
    n = 0;
    while (cw_on && n < 2000) begin
      check_condition(tx_on, "tx_on dropped before cw_on");
      @(negedge clk);
      n++;
    end
    check_condition(!cw_on && !tx_on, "CW did not end after hang");
    // Latency hold, one tick per 16 clocks of the ramp down, then the hang
    compare_value(64'(pulses_seen - base), 64'(8 + CW_STEPS / 16 + 4), "CW release ticks");

    // Run gating during PTT and then during CW
    tx_tuser  = 4'b1000;
    tx_tvalid = 1'b1;
    n = 0;
    while (!(tx_on && tx_tready) && n < 400) begin
      @(negedge clk);
      n++;
    end
    check_condition(tx_on && tx_tready, "PTT did not start before run gating");
    run       = 1'b0;
    tx_tuser  = '0;
    tx_tvalid = 1'b0;
    @(negedge clk);
    check_condition(!tx_on && !cw_on, "run low did not stop PTT");
    run = 1'b1;
    ext_keydown = 1'b1;
    n = 0;
    while (!cw_on && n < 400) begin
      @(negedge clk);
      n++;
    end
    check_condition(cw_on, "cw_on did not rise before run gating");
    run = 1'b0;
    ext_keydown = 1'b0;
    @(negedge clk);
    check_condition(!tx_on && !cw_on, "run low did not stop CW");
    run = 1'b1;
    repeat (4) @(negedge clk);

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/radio_ctrl_pkg.sv
source/radio_sig_pkg.sv
source/cmd_decoder.sv
source/phase_bank.sv
source/tx_keyer.sv
source/rx_framer.sv
source/radio_top.sv
tests/radio_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the radio testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module radio_tb \
  --Mdir obj_dir -o radio_tb > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/radio_tb > run.log 2>&1 \
  || { echo "Simulation exited with an error, see run.log"; exit 1; }

grep -q "FAIL: see errors above" run.log \
  && { echo "Simulation failed, see run.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
